/* common/turfio_ctrl_defines.svh */
`ifndef TURFIO_CTRL_DEFINES_SVH
`define TURFIO_CTRL_DEFINES_SVH

// lanes are fixed by the address map
`define TURFIO_NUM_LANES 4
`define TURFIO_WB_ADDR_W 15

// address decode bits
// 0x4000-0x7fff is DRP, one 4k window per lane
`define TURFIO_DRP_SPACE_BIT 14
`define TURFIO_DRP_LANE_LSB 12
// 0x2000-0x3fff is global, below that 2k per lane
`define TURFIO_GLOBAL_BIT 13
`define TURFIO_LANE_SEL_LSB 11

// word offsets inside a lane block
`define TURFIO_REG_CTRL 2'd0
`define TURFIO_REG_STATUS 2'd1
`define TURFIO_REG_EYESCAN 2'd2
`define TURFIO_REG_DMON 2'd3

// default tx swing
`define TURFIO_TXDIFF_RESET 4'd12

// control word fields
`define TURFIO_CTRL_RESET_BIT 0
`define TURFIO_CTRL_GT_RESET_BIT 1
`define TURFIO_CTRL_EYESCAN_RESET_BIT 2
`define TURFIO_CTRL_POWERDOWN_BIT 3
`define TURFIO_CTRL_LOOPBACK_LSB 4
`define TURFIO_CTRL_DATAPATH_RESET_BIT 30
`define TURFIO_CTRL_LINKERR_RESET_BIT 31

// eyescan word fields
`define TURFIO_ES_SWING_LSB 0
`define TURFIO_ES_PRECURSOR_LSB 8
`define TURFIO_ES_POSTCURSOR_LSB 16

`endif

/* common/turfio_ctrl_pkg.sv */
`include "turfio_ctrl_defines.svh"

package turfio_ctrl_pkg;

    // wishbone side
    typedef logic [`TURFIO_WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0] wb_sel_t;

    // lane index, both in control and DRP space
    typedef logic [1:0] lane_sel_t;

    // transceiver DRP
    typedef logic [9:0] drp_addr_t;
    typedef logic [15:0] drp_data_t;

    // raw lane status, bit 0 upwards
    // lane up, channel up, power good, tx lock,
    // tx reset done, rx reset done, link reset, system reset,
    // hard err, soft err, frame err, buffer clear
    typedef logic [11:0] link_stat_t;

    // per-lane transceiver controls
    typedef logic [2:0] loopback_t;
    typedef logic [3:0] txdiff_t;
    typedef logic [4:0] cursor_t;

    // bus cycle
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACK,
        ST_DRP_WAIT
    } wb_state_t;

endpackage

/* wb_ctrl/wb_cycle_fsm.sv */
`timescale 1ns/10ps
`include "turfio_ctrl_defines.svh"

module wb_cycle_fsm import turfio_ctrl_pkg::*; (
    input  logic                                 user_clk,
    input  logic                                 user_aresetn,
    // wishbone target
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  wb_addr_t                             wb_adr_i,
    input  wb_data_t                             wb_dat_i,
    input  wb_sel_t                              wb_sel_i,
    output wb_data_t                             wb_dat_o,
    output logic                                 wb_ack_o,
    // DRP ports, only en and rdy are per lane
    output logic [`TURFIO_NUM_LANES-1:0]         drp_en_o,
    output logic                                 drp_we_o,
    output drp_addr_t                            drp_addr_o,
    output drp_data_t                            drp_di_o,
    input  logic [`TURFIO_NUM_LANES-1:0]         drp_rdy_i,
    input  drp_data_t [`TURFIO_NUM_LANES-1:0]    drp_do_i,
    // register bank access
    output logic                                 reg_we_o,
    output wb_addr_t                             reg_adr_o,
    output wb_data_t                             reg_dat_o,
    output wb_sel_t                              reg_sel_o,
    input  wb_data_t                             reg_rdata_i
);

    wb_state_t state;
    logic      wb_req;
    logic      drp_space;
    lane_sel_t drp_lane;
    logic      drp_lane_rdy;
    drp_data_t drp_lane_do;

    assign wb_req    = wb_cyc_i && wb_stb_i;
    // upper half of the address space goes to DRP
    assign drp_space = wb_adr_i[`TURFIO_DRP_SPACE_BIT];
    // lane window inside DRP space
    assign drp_lane  = wb_adr_i[`TURFIO_DRP_LANE_LSB +: 2];

    // only the addressed lane's ready and data matter
    assign drp_lane_rdy = drp_rdy_i[drp_lane];
    assign drp_lane_do  = drp_do_i[drp_lane];

    // shared DRP fields come straight off the bus
    // word address, so the byte bits are dropped
    assign drp_addr_o = wb_adr_i[2 +: $bits(drp_addr_t)];
    assign drp_di_o   = wb_dat_i[$bits(drp_data_t)-1:0];
    assign drp_we_o   = wb_we_i;

    // en fires in the idle cycle that sees the request
    // the state moves on at the next edge so this is one cycle wide
    always_comb begin
        drp_en_o = '0;
        if (state == ST_IDLE && wb_req && drp_space) begin
            drp_en_o[drp_lane] = 1'b1;
        end
    end

    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wb_req) begin
                        // control space answers next cycle
                        state <= drp_space ? ST_DRP_WAIT : ST_ACK;
                    end
                end
                ST_DRP_WAIT: begin
                    // wait as long as the transceiver needs
                    if (drp_lane_rdy) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // read data is captured so it is valid together with ack
    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            wb_dat_o <= '0;
        end else if (state == ST_IDLE && wb_req && !drp_space && !wb_we_i) begin
            wb_dat_o <= reg_rdata_i;
        end else if (state == ST_DRP_WAIT && drp_lane_rdy && !wb_we_i) begin
            // DRP is 16 bits wide, zero-extend
            wb_dat_o <= {{($bits(wb_data_t) - $bits(drp_data_t)){1'b0}}, drp_lane_do};
        end
    end

    assign wb_ack_o = (state == ST_ACK);

    // write strobe lines up with the control-space ack
    // master still holds address and data here
    assign reg_we_o  = wb_ack_o && wb_req && wb_we_i && !drp_space;
    assign reg_adr_o = wb_adr_i;
    assign reg_dat_o = wb_dat_i;
    assign reg_sel_o = wb_sel_i;

endmodule

/* wb_ctrl/link_reg_bank.sv */
`timescale 1ns/10ps
`include "turfio_ctrl_defines.svh"

module link_reg_bank import turfio_ctrl_pkg::*; (
    input  logic                                 user_clk,
    input  logic                                 user_aresetn,
    // access from the bus controller
    input  logic                                 reg_we_i,
    input  wb_addr_t                             reg_adr_i,
    input  wb_data_t                             reg_dat_i,
    input  wb_sel_t                              reg_sel_i,
    output wb_data_t                             reg_rdata_o,
    // lane monitoring
    input  link_stat_t [`TURFIO_NUM_LANES-1:0]   link_stat_i,
    input  logic [`TURFIO_NUM_LANES-1:0][15:0]   dmonitor_i,
    // global controls
    output logic                                 reset_o,
    output logic                                 gt_reset_o,
    output logic                                 datapath_reset_o,
    output logic                                 linkerr_reset_o,
    // per-lane controls
    output logic [`TURFIO_NUM_LANES-1:0]         eyescan_reset_o,
    output logic [`TURFIO_NUM_LANES-1:0]         powerdown_o,
    output logic [`TURFIO_NUM_LANES-1:0]         lane_datapath_reset_o,
    output logic [`TURFIO_NUM_LANES-1:0]         lane_linkerr_reset_o,
    output loopback_t [`TURFIO_NUM_LANES-1:0]    loopback_o,
    output txdiff_t [`TURFIO_NUM_LANES-1:0]      tx_diffctrl_o,
    output cursor_t [`TURFIO_NUM_LANES-1:0]      tx_precursor_o,
    output cursor_t [`TURFIO_NUM_LANES-1:0]      tx_postcursor_o,
    output logic [`TURFIO_NUM_LANES-1:0]         aurora_up_o
);

    logic       glob_sel;
    lane_sel_t  lane_sel;
    logic [1:0] word_sel;
    logic       glob_we;
    logic       ctrl_we;
    logic       es_we;
    wb_data_t   glob_word;
    wb_data_t   ctrl_word;
    wb_data_t   es_word;

    // address decode
    assign glob_sel = reg_adr_i[`TURFIO_GLOBAL_BIT];
    assign lane_sel = reg_adr_i[`TURFIO_LANE_SEL_LSB +: 2];
    // 32-bit words, offset starts above the byte bits
    assign word_sel = reg_adr_i[3:2];

    assign glob_we = reg_we_i && glob_sel && (word_sel == `TURFIO_REG_CTRL);
    assign ctrl_we = reg_we_i && !glob_sel && (word_sel == `TURFIO_REG_CTRL);
    assign es_we   = reg_we_i && !glob_sel && (word_sel == `TURFIO_REG_EYESCAN);

    // global word, byte 0 holds the resets, byte 3 the datapath and error resets
    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            reset_o          <= 1'b0;
            gt_reset_o       <= 1'b0;
            datapath_reset_o <= 1'b0;
            linkerr_reset_o  <= 1'b0;
        end else if (glob_we) begin
            if (reg_sel_i[0]) begin
                reset_o    <= reg_dat_i[`TURFIO_CTRL_RESET_BIT];
                gt_reset_o <= reg_dat_i[`TURFIO_CTRL_GT_RESET_BIT];
            end
            if (reg_sel_i[3]) begin
                datapath_reset_o <= reg_dat_i[`TURFIO_CTRL_DATAPATH_RESET_BIT];
                linkerr_reset_o  <= reg_dat_i[`TURFIO_CTRL_LINKERR_RESET_BIT];
            end
        end
    end

    // per-lane control and eyescan, each byte lane written on its own
    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            eyescan_reset_o       <= '0;
            powerdown_o           <= '0;
            lane_datapath_reset_o <= '0;
            lane_linkerr_reset_o  <= '0;
            loopback_o            <= '0;
            tx_precursor_o        <= '0;
            tx_postcursor_o       <= '0;
            for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
                tx_diffctrl_o[i] <= `TURFIO_TXDIFF_RESET;
            end
        end else begin
            for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
                if (ctrl_we && lane_sel == lane_sel_t'(i)) begin
                    // bits 0 and 1 live in the global word
                    if (reg_sel_i[0]) begin
                        eyescan_reset_o[i] <= reg_dat_i[`TURFIO_CTRL_EYESCAN_RESET_BIT];
                        powerdown_o[i]     <= reg_dat_i[`TURFIO_CTRL_POWERDOWN_BIT];
                        loopback_o[i]      <=
                            reg_dat_i[`TURFIO_CTRL_LOOPBACK_LSB +: $bits(loopback_t)];
                    end
                    if (reg_sel_i[3]) begin
                        lane_datapath_reset_o[i] <= reg_dat_i[`TURFIO_CTRL_DATAPATH_RESET_BIT];
                        lane_linkerr_reset_o[i]  <= reg_dat_i[`TURFIO_CTRL_LINKERR_RESET_BIT];
                    end
                end
                if (es_we && lane_sel == lane_sel_t'(i)) begin
                    if (reg_sel_i[0]) begin
                        tx_diffctrl_o[i] <= reg_dat_i[`TURFIO_ES_SWING_LSB +: $bits(txdiff_t)];
                    end
                    if (reg_sel_i[1]) begin
                        tx_precursor_o[i] <=
                            reg_dat_i[`TURFIO_ES_PRECURSOR_LSB +: $bits(cursor_t)];
                    end
                    if (reg_sel_i[2]) begin
                        tx_postcursor_o[i] <=
                            reg_dat_i[`TURFIO_ES_POSTCURSOR_LSB +: $bits(cursor_t)];
                    end
                end
            end
        end
    end

    // read words, assembled for the addressed lane only
    always_comb begin
        glob_word = '0;
        glob_word[`TURFIO_CTRL_RESET_BIT]          = reset_o;
        glob_word[`TURFIO_CTRL_GT_RESET_BIT]       = gt_reset_o;
        glob_word[`TURFIO_CTRL_DATAPATH_RESET_BIT] = datapath_reset_o;
        glob_word[`TURFIO_CTRL_LINKERR_RESET_BIT]  = linkerr_reset_o;

        // global resets show up in every lane's control word
        ctrl_word = '0;
        ctrl_word[`TURFIO_CTRL_RESET_BIT]          = reset_o;
        ctrl_word[`TURFIO_CTRL_GT_RESET_BIT]       = gt_reset_o;
        ctrl_word[`TURFIO_CTRL_EYESCAN_RESET_BIT]  = eyescan_reset_o[lane_sel];
        ctrl_word[`TURFIO_CTRL_POWERDOWN_BIT]      = powerdown_o[lane_sel];
        ctrl_word[`TURFIO_CTRL_LOOPBACK_LSB +: $bits(loopback_t)] = loopback_o[lane_sel];
        ctrl_word[`TURFIO_CTRL_DATAPATH_RESET_BIT] = lane_datapath_reset_o[lane_sel];
        ctrl_word[`TURFIO_CTRL_LINKERR_RESET_BIT]  = lane_linkerr_reset_o[lane_sel];

        es_word = '0;
        es_word[`TURFIO_ES_SWING_LSB +: $bits(txdiff_t)]      = tx_diffctrl_o[lane_sel];
        es_word[`TURFIO_ES_PRECURSOR_LSB +: $bits(cursor_t)]  = tx_precursor_o[lane_sel];
        es_word[`TURFIO_ES_POSTCURSOR_LSB +: $bits(cursor_t)] = tx_postcursor_o[lane_sel];
    end

    always_comb begin
        reg_rdata_o = '0;
        if (glob_sel) begin
            // only one global word, offset is ignored
            reg_rdata_o = glob_word;
        end else begin
            case (word_sel)
                `TURFIO_REG_CTRL:    reg_rdata_o = ctrl_word;
                `TURFIO_REG_STATUS:  reg_rdata_o = wb_data_t'(link_stat_i[lane_sel]);
                `TURFIO_REG_EYESCAN: reg_rdata_o = es_word;
                `TURFIO_REG_DMON:    reg_rdata_o = wb_data_t'(dmonitor_i[lane_sel]);
                default:             reg_rdata_o = '0;
            endcase
        end
    end

    // link is up once both lane up and channel up are set
    // status bit 0 is lane up, bit 1 channel up
    always_comb begin
        for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
            aurora_up_o[i] = link_stat_i[i][0] && link_stat_i[i][1];
        end
    end

endmodule

/* verilog/turfio_ctrl_top.sv */
`timescale 1ns/10ps
`include "turfio_ctrl_defines.svh"

module turfio_ctrl_top import turfio_ctrl_pkg::*; (
    input  logic                                 user_clk,
    input  logic                                 user_aresetn,
    // wishbone target
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  wb_addr_t                             wb_adr_i,
    input  wb_data_t                             wb_dat_i,
    input  wb_sel_t                              wb_sel_i,
    output wb_data_t                             wb_dat_o,
    output logic                                 wb_ack_o,
    // DRP towards the transceivers
    output logic [`TURFIO_NUM_LANES-1:0]         drp_en_o,
    output logic                                 drp_we_o,
    output drp_addr_t                            drp_addr_o,
    output drp_data_t                            drp_di_o,
    input  logic [`TURFIO_NUM_LANES-1:0]         drp_rdy_i,
    input  drp_data_t [`TURFIO_NUM_LANES-1:0]    drp_do_i,
    // lane monitoring
    input  link_stat_t [`TURFIO_NUM_LANES-1:0]   link_stat_i,
    input  logic [`TURFIO_NUM_LANES-1:0][15:0]   dmonitor_i,
    // global controls
    output logic                                 reset_o,
    output logic                                 gt_reset_o,
    output logic                                 datapath_reset_o,
    output logic                                 linkerr_reset_o,
    // per-lane controls
    output logic [`TURFIO_NUM_LANES-1:0]         eyescan_reset_o,
    output logic [`TURFIO_NUM_LANES-1:0]         powerdown_o,
    output logic [`TURFIO_NUM_LANES-1:0]         lane_datapath_reset_o,
    output logic [`TURFIO_NUM_LANES-1:0]         lane_linkerr_reset_o,
    output loopback_t [`TURFIO_NUM_LANES-1:0]    loopback_o,
    output txdiff_t [`TURFIO_NUM_LANES-1:0]      tx_diffctrl_o,
    output cursor_t [`TURFIO_NUM_LANES-1:0]      tx_precursor_o,
    output cursor_t [`TURFIO_NUM_LANES-1:0]      tx_postcursor_o,
    output logic [`TURFIO_NUM_LANES-1:0]         aurora_up_o
);

    // register access from the bus controller
    logic     reg_we;
    wb_addr_t reg_adr;
    wb_data_t reg_dat;
    wb_sel_t  reg_sel;
    // combinational read word back from the bank
    wb_data_t reg_rdata;

    wb_cycle_fsm u_wb_cycle_fsm (
        .user_clk     (user_clk),
        .user_aresetn (user_aresetn),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .drp_en_o     (drp_en_o),
        .drp_we_o     (drp_we_o),
        .drp_addr_o   (drp_addr_o),
        .drp_di_o     (drp_di_o),
        .drp_rdy_i    (drp_rdy_i),
        .drp_do_i     (drp_do_i),
        .reg_we_o     (reg_we),
        .reg_adr_o    (reg_adr),
        .reg_dat_o    (reg_dat),
        .reg_sel_o    (reg_sel),
        .reg_rdata_i  (reg_rdata)
    );

    link_reg_bank u_link_reg_bank (
        .user_clk              (user_clk),
        .user_aresetn          (user_aresetn),
        .reg_we_i              (reg_we),
        .reg_adr_i             (reg_adr),
        .reg_dat_i             (reg_dat),
        .reg_sel_i             (reg_sel),
        .reg_rdata_o           (reg_rdata),
        .link_stat_i           (link_stat_i),
        .dmonitor_i            (dmonitor_i),
        .reset_o               (reset_o),
        .gt_reset_o            (gt_reset_o),
        .datapath_reset_o      (datapath_reset_o),
        .linkerr_reset_o       (linkerr_reset_o),
        .eyescan_reset_o       (eyescan_reset_o),
        .powerdown_o           (powerdown_o),
        .lane_datapath_reset_o (lane_datapath_reset_o),
        .lane_linkerr_reset_o  (lane_linkerr_reset_o),
        .loopback_o            (loopback_o),
        .tx_diffctrl_o         (tx_diffctrl_o),
        .tx_precursor_o        (tx_precursor_o),
        .tx_postcursor_o       (tx_postcursor_o),
        .aurora_up_o           (aurora_up_o)
    );

endmodule

/* bench/turfio_ctrl_sva.sv */
`timescale 1ns/10ps

module turfio_ctrl_sva (
    input logic       user_clk,
    input logic       user_aresetn,
    input logic       wb_cyc_i,
    input logic       wb_stb_i,
    input logic       wb_ack_o,
    input logic [3:0] drp_en_o
);

    // failures seen so far, read back by the testbench at the end
    int fail_count = 0;

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        wb_ack_o |=> !wb_ack_o)
        else begin
            fail_count++;
            $error("wb_ack_o held for more than one cycle");
        end

    // en goes to one lane at a time
    drp_en_onehot: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        $onehot0(drp_en_o))
        else begin
            fail_count++;
            $error("more than one drp_en_o bit high");
        end

    // a new DRP access never starts during an ack
    drp_en_not_in_ack: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        $rose(|drp_en_o) |-> !wb_ack_o)
        else begin
            fail_count++;
            $error("drp_en_o rose while wb_ack_o was high");
        end

    // ack only answers a live request
    ack_needs_stb: assert property (@(posedge user_clk) disable iff (!user_aresetn)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else begin
            fail_count++;
            $error("wb_ack_o without cyc and stb");
        end

endmodule

bind turfio_ctrl_top turfio_ctrl_sva u_turfio_ctrl_sva (.*);

/* bench/tb_turfio_ctrl.sv */
`timescale 1ns/10ps
`include "turfio_ctrl_defines.svh"

module tb_turfio_ctrl import turfio_ctrl_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int ACK_LIMIT   = 40;
    // rough upper bound on bus transactions over all tests
    localparam int NUM_TXN     = 200;
    localparam int WATCHDOG_CYCLES = NUM_TXN * 20 + 300;
    // implemented bits of each register word
    localparam logic [31:0] GLOB_BITS = 32'hc000_0003;
    localparam logic [31:0] CTRL_BITS = 32'hc000_007c;
    localparam logic [31:0] ES_BITS   = 32'h001f_1f0f;

    logic user_clk = 1'b0;
    logic user_aresetn;
    logic wb_cyc_i, wb_stb_i, wb_we_i;
    wb_addr_t wb_adr_i;
    wb_data_t wb_dat_i;
    wb_sel_t  wb_sel_i;
    wb_data_t wb_dat_o;
    logic     wb_ack_o;
    logic [`TURFIO_NUM_LANES-1:0] drp_en_o;
    logic drp_we_o;
    drp_addr_t drp_addr_o;
    drp_data_t drp_di_o;
    logic [`TURFIO_NUM_LANES-1:0] drp_rdy_i;
    drp_data_t [`TURFIO_NUM_LANES-1:0] drp_do_i;
    link_stat_t [`TURFIO_NUM_LANES-1:0] link_stat_i;
    logic [`TURFIO_NUM_LANES-1:0][15:0] dmonitor_i;
    logic reset_o, gt_reset_o, datapath_reset_o, linkerr_reset_o;
    logic [`TURFIO_NUM_LANES-1:0] eyescan_reset_o, powerdown_o;
    logic [`TURFIO_NUM_LANES-1:0] lane_datapath_reset_o, lane_linkerr_reset_o;
    loopback_t [`TURFIO_NUM_LANES-1:0] loopback_o;
    txdiff_t [`TURFIO_NUM_LANES-1:0] tx_diffctrl_o;
    cursor_t [`TURFIO_NUM_LANES-1:0] tx_precursor_o, tx_postcursor_o;
    logic [`TURFIO_NUM_LANES-1:0] aurora_up_o;

    // shadow registers
    logic [31:0] sh_glob;
    logic [31:0] sh_ctrl [`TURFIO_NUM_LANES];
    logic [31:0] sh_es [`TURFIO_NUM_LANES];
    // expected read words in ack order
    logic [31:0] exp_q [$];
    // what the DRP responder saw
    logic [3:0]  seen_en;
    drp_addr_t   seen_addr;
    drp_data_t   seen_di;
    logic        seen_we;
    int          en_count = 0;
    int          error_count = 0;
    logic [31:0] lfsr = 32'd96455;

    turfio_ctrl_top u_turfio_ctrl_top (.*);

    always #(CLK_PERIOD / 2) user_clk = ~user_clk;

    // fibonacci LFSR with taps 32 22 2 1
    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // byte-lane write into the shadow copy
    function automatic void shadow_write(input wb_addr_t adr, input wb_data_t dat,
                                         input wb_sel_t sel);
        logic [31:0] mask;
        int lane;
        mask = '0;
        lane = adr[`TURFIO_LANE_SEL_LSB +: 2];
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                mask[8*b +: 8] = 8'hff;
            end
        end
        if (adr[`TURFIO_GLOBAL_BIT]) begin
            if (adr[3:2] == `TURFIO_REG_CTRL) begin
                sh_glob = (sh_glob & ~mask) | (dat & mask & GLOB_BITS);
            end
        end else if (adr[3:2] == `TURFIO_REG_CTRL) begin
            sh_ctrl[lane] = (sh_ctrl[lane] & ~mask) | (dat & mask & CTRL_BITS);
        end else if (adr[3:2] == `TURFIO_REG_EYESCAN) begin
            sh_es[lane] = (sh_es[lane] & ~mask) | (dat & mask & ES_BITS);
        end
    endfunction

    // reference read word for a control-space address
    function automatic logic [31:0] expected_read(input wb_addr_t adr);
        int lane;
        lane = adr[`TURFIO_LANE_SEL_LSB +: 2];
        if (adr[`TURFIO_GLOBAL_BIT]) begin
            return sh_glob;
        end
        case (adr[3:2])
            `TURFIO_REG_CTRL:    return sh_ctrl[lane] | (sh_glob & 32'h3);
            `TURFIO_REG_STATUS:  return {20'h0, link_stat_i[lane]};
            `TURFIO_REG_EYESCAN: return sh_es[lane];
            default:             return {16'h0, dmonitor_i[lane]};
        endcase
    endfunction

    function automatic wb_addr_t lane_addr(input int lane, input logic [1:0] off);
        return wb_addr_t'((lane << `TURFIO_LANE_SEL_LSB) | (off << 2));
    endfunction

    // starts at the drive point and ends at the drive point after the ack
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             input wb_sel_t sel);
        int waited;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        waited = 0;
        do begin
            @(negedge user_clk);
            waited++;
        end while (!wb_ack_o && waited < ACK_LIMIT);
        if (!wb_ack_o) begin
            error_count++;
            $display("no ack within %0d cycles for address 0x%h", ACK_LIMIT, adr);
        end
        @(posedge user_clk);
        #DRIVE_DELAY;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic write_reg(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel);
        bus_cycle(1'b1, adr, dat, sel);
        shadow_write(adr, dat, sel);
    endtask

    task automatic read_reg(input wb_addr_t adr);
        exp_q.push_back(expected_read(adr));
        bus_cycle(1'b0, adr, '0, 4'hf);
    endtask

    task automatic check_outputs();
        check_value("reset_o", reset_o, sh_glob[0]);
        check_value("gt_reset_o", gt_reset_o, sh_glob[1]);
        check_value("datapath_reset_o", datapath_reset_o, sh_glob[30]);
        check_value("linkerr_reset_o", linkerr_reset_o, sh_glob[31]);
        for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
            check_value($sformatf("eyescan_reset_o[%0d]", i), eyescan_reset_o[i], sh_ctrl[i][2]);
            check_value($sformatf("powerdown_o[%0d]", i), powerdown_o[i], sh_ctrl[i][3]);
            check_value($sformatf("loopback_o[%0d]", i), loopback_o[i], sh_ctrl[i][6:4]);
            check_value($sformatf("lane_datapath_reset_o[%0d]", i),
                        lane_datapath_reset_o[i], sh_ctrl[i][30]);
            check_value($sformatf("lane_linkerr_reset_o[%0d]", i),
                        lane_linkerr_reset_o[i], sh_ctrl[i][31]);
            check_value($sformatf("tx_diffctrl_o[%0d]", i), tx_diffctrl_o[i], sh_es[i][3:0]);
            check_value($sformatf("tx_precursor_o[%0d]", i), tx_precursor_o[i], sh_es[i][12:8]);
            check_value($sformatf("tx_postcursor_o[%0d]", i), tx_postcursor_o[i],
                        sh_es[i][20:16]);
        end
    endtask

    // compares every read ack against the oldest expected word
    always @(negedge user_clk) begin
        if (user_aresetn && wb_ack_o && !wb_we_i) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("read ack arrived with no expected word queued");
            end else begin
                check_value("wb_dat_o", wb_dat_o, exp_q.pop_front());
            end
        end
    end

    // counts every cycle with an enable high so a stretched pulse shows up
    always @(negedge user_clk) begin
        if (user_aresetn && drp_en_o != '0) begin
            en_count++;
        end
    end

    // acts as the transceiver DRP side
    initial begin : drp_responder
        int lane;
        int delay;
        drp_data_t rd;
        forever begin
            @(negedge user_clk);
            if (drp_en_o != '0) begin
                seen_en   = drp_en_o;
                seen_addr = drp_addr_o;
                seen_di   = drp_di_o;
                seen_we   = drp_we_o;
                lane = 0;
                for (int i = `TURFIO_NUM_LANES - 1; i >= 0; i--) begin
                    if (drp_en_o[i]) begin
                        lane = i;
                    end
                end
                delay = 1 + rand_bits(3);
                repeat (delay) @(posedge user_clk);
                #DRIVE_DELAY;
                // other lanes carry noise so a wrong steer shows up
                for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
                    drp_do_i[i] = rand_bits(16);
                end
                if (!seen_we) begin
                    rd = rand_bits(16);
                    drp_do_i[lane] = rd;
                    exp_q.push_back({16'h0, rd});
                end
                drp_rdy_i[lane] = 1'b1;
                @(posedge user_clk);
                #DRIVE_DELAY;
                drp_rdy_i[lane] = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        int lane;
        int base_en;
        wb_addr_t adr;
        wb_data_t dat;
        drp_addr_t daddr;
        int sva_fails;
        user_aresetn = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        drp_rdy_i = '0;
        drp_do_i = '0;
        link_stat_i = '0;
        dmonitor_i = '0;
        sh_glob = '0;
        for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
            sh_ctrl[i] = '0;
            sh_es[i] = 32'(`TURFIO_TXDIFF_RESET);
        end
        repeat (10) @(posedge user_clk);
        #DRIVE_DELAY;
        user_aresetn = 1'b1;

        // reset values and default reads
        check_value("wb_ack_o", wb_ack_o, 0);
        check_value("wb_dat_o", wb_dat_o, 0);
        check_value("drp_en_o", drp_en_o, 0);
        check_value("aurora_up_o", aurora_up_o, 0);
        check_outputs();
        read_reg(wb_addr_t'(1 << `TURFIO_GLOBAL_BIT));
        for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
            read_reg(lane_addr(i, `TURFIO_REG_CTRL));
            read_reg(lane_addr(i, `TURFIO_REG_EYESCAN));
            read_reg(lane_addr(i, `TURFIO_REG_STATUS));
        end

        // global word also shows in every lane control word
        repeat (3) begin
            write_reg(wb_addr_t'(1 << `TURFIO_GLOBAL_BIT), rand_bits(32), 4'hf);
            check_outputs();
            read_reg(wb_addr_t'(1 << `TURFIO_GLOBAL_BIT));
            for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
                read_reg(lane_addr(i, `TURFIO_REG_CTRL));
            end
        end

        // random lane writes under random byte selects
        repeat (40) begin
            lane = rand_bits(2);
            adr = lane_addr(lane, rand_bits(1) ? `TURFIO_REG_EYESCAN : `TURFIO_REG_CTRL);
            write_reg(adr, rand_bits(32), rand_bits(4));
            check_outputs();
            read_reg(adr);
        end

        // status and dmonitor passthrough
        repeat (3) begin
            for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
                link_stat_i[i] = rand_bits(12);
                dmonitor_i[i] = rand_bits(16);
            end
            for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
                read_reg(lane_addr(i, `TURFIO_REG_STATUS));
                read_reg(lane_addr(i, `TURFIO_REG_DMON));
                // lane up is bit 0 and channel up bit 1
                check_value($sformatf("aurora_up_o[%0d]", i), aurora_up_o[i],
                            link_stat_i[i][0] & link_stat_i[i][1]);
            end
        end
        check_value("drp_en_o pulse count", en_count, 0);

        // DRP writes then reads on each lane
        for (int i = 0; i < `TURFIO_NUM_LANES; i++) begin
            repeat (2) begin
                daddr = rand_bits(10);
                dat = rand_bits(32);
                adr = wb_addr_t'((1 << `TURFIO_DRP_SPACE_BIT) | (i << `TURFIO_DRP_LANE_LSB)
                                 | (daddr << 2));
                base_en = en_count;
                bus_cycle(1'b1, adr, dat, 4'hf);
                check_value("drp_en_o pulse count", en_count - base_en, 1);
                check_value("drp_en_o", seen_en, 1 << i);
                check_value("drp_addr_o", seen_addr, daddr);
                check_value("drp_di_o", seen_di, dat[15:0]);
                check_value("drp_we_o", seen_we, 1);
                daddr = rand_bits(10);
                adr = wb_addr_t'((1 << `TURFIO_DRP_SPACE_BIT) | (i << `TURFIO_DRP_LANE_LSB)
                                 | (daddr << 2));
                base_en = en_count;
                bus_cycle(1'b0, adr, '0, 4'hf);
                check_value("drp_en_o pulse count", en_count - base_en, 1);
                check_value("drp_en_o", seen_en, 1 << i);
                check_value("drp_addr_o", seen_addr, daddr);
                check_value("drp_we_o", seen_we, 0);
            end
        end

        repeat (4) @(posedge user_clk);
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected read words were never compared", exp_q.size());
        end
        sva_fails = u_turfio_ctrl_top.u_turfio_ctrl_sva.fail_count;
        $display("run complete: %0d check errors, %0d assertion failures",
                 error_count, sva_fails);
        if (error_count == 0 && sva_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+common
common/turfio_ctrl_pkg.sv
wb_ctrl/wb_cycle_fsm.sv
wb_ctrl/link_reg_bank.sv
verilog/turfio_ctrl_top.sv
bench/turfio_ctrl_sva.sv
bench/tb_turfio_ctrl.sv
